//--- hazardCtrl.f
+incdir+include
verilog/hazardPkg.sv
verilog/stageIf.sv
verilog/stageDecode.sv
verilog/pipeTracker.sv
verilog/forwardSelect.sv
verilog/redirectCtrl.sv
verilog/hazardCtrl.sv
testbench/hazardCtrlTb.sv

//--- Makefile
TOOL = verilator
FLAGS = --timing --assert
TOP = hazardCtrlTb
FILELIST = hazardCtrl.f
BUILD = obj_dir
LOG = sim.log

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(TOOL) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- include/hazardModel.svh
`ifndef HAZARD_MODEL_SVH
`define HAZARD_MODEL_SVH

typedef struct packed {
	hazardPkg::instWord_t ex;
	hazardPkg::instWord_t mem;
	hazardPkg::instWord_t wb;
} modelState_t;

typedef struct packed {
	hazardPkg::fwdSel_e fwdA;
	hazardPkg::fwdSel_e fwdB;
	hazardPkg::fwdSel_e fwdStore;
	logic stall;
	logic flush;
	logic pcSelect;
} modelOut_t;

function automatic logic [31:0] xorshift32(input logic [31:0] s);
	logic [31:0] x;
	x = s;
	x = x ^ (x << 13);
	x = x ^ (x >> 17);
	x = x ^ (x << 5);
	return x;
endfunction

// Immediate bits are don't care for hazard control
function automatic hazardPkg::instWord_t mkInst(input logic [6:0] op,
	input hazardPkg::regAddr_t rd, input hazardPkg::regAddr_t rs1,
	input hazardPkg::regAddr_t rs2, input logic [2:0] f3);
	return {7'b0, rs2, rs1, f3, rd, op};
endfunction

function automatic hazardPkg::instWord_t mkAlu(input hazardPkg::regAddr_t rd,
	input hazardPkg::regAddr_t rs1, input hazardPkg::regAddr_t rs2);
	return mkInst(hazardPkg::opR, rd, rs1, rs2, 3'b000);
endfunction

function automatic hazardPkg::instWord_t mkLoad(input hazardPkg::regAddr_t rd,
	input hazardPkg::regAddr_t rs1);
	return mkInst(hazardPkg::opLoad, rd, rs1, 5'd0, 3'b010);
endfunction

function automatic hazardPkg::instWord_t mkStore(input hazardPkg::regAddr_t rs1,
	input hazardPkg::regAddr_t rs2);
	return mkInst(hazardPkg::opStore, 5'd0, rs1, rs2, 3'b010);
endfunction

function automatic hazardPkg::instWord_t mkBranch(input logic [2:0] f3,
	input hazardPkg::regAddr_t rs1, input hazardPkg::regAddr_t rs2);
	return mkInst(hazardPkg::opBranch, 5'd0, rs1, rs2, f3);
endfunction

function automatic hazardPkg::instWord_t mkJal(input hazardPkg::regAddr_t rd);
	return mkInst(hazardPkg::opJal, rd, 5'd0, 5'd0, 3'b000);
endfunction

function automatic hazardPkg::instWord_t mkJalr(input hazardPkg::regAddr_t rd,
	input hazardPkg::regAddr_t rs1);
	return mkInst(hazardPkg::opJalr, rd, rs1, 5'd0, 3'b000);
endfunction

// Registers x0 to x3 only, so hazards are frequent
function automatic hazardPkg::instWord_t randInst(input logic [31:0] r);
	logic [6:0] op;
	case (r[3:0])
		4'd0, 4'd1: op = hazardPkg::opR;
		4'd2, 4'd3: op = hazardPkg::opI;
		4'd4, 4'd5: op = hazardPkg::opLoad;
		4'd6, 4'd12: op = hazardPkg::opStore;
		4'd7, 4'd13: op = hazardPkg::opBranch;
		4'd8: op = hazardPkg::opJal;
		4'd9: op = hazardPkg::opJalr;
		4'd10: op = hazardPkg::opLui;
		4'd11: op = hazardPkg::opAuipc;
		default: op = 7'd0;
	endcase
	if (op == 7'd0)
		return hazardPkg::bubbleInst;
	return mkInst(op, {3'b0, r[5:4]}, {3'b0, r[7:6]}, {3'b0, r[9:8]}, r[12:10]);
endfunction

function automatic logic mReadsRs1(input hazardPkg::instWord_t i);
	return (i[6:0] inside {hazardPkg::opR, hazardPkg::opI, hazardPkg::opLoad,
		hazardPkg::opStore, hazardPkg::opBranch, hazardPkg::opJalr}) && (i[19:15] != '0);
endfunction

function automatic logic mReadsRs2(input hazardPkg::instWord_t i);
	return (i[6:0] inside {hazardPkg::opR, hazardPkg::opStore, hazardPkg::opBranch})
		&& (i[24:20] != '0);
endfunction

function automatic logic mWritesRd(input hazardPkg::instWord_t i);
	return (i[6:0] inside {hazardPkg::opR, hazardPkg::opI, hazardPkg::opLui,
		hazardPkg::opAuipc, hazardPkg::opLoad, hazardPkg::opJal, hazardPkg::opJalr})
		&& (i[11:7] != '0);
endfunction

function automatic hazardPkg::fwdSel_e mSrc(input hazardPkg::regAddr_t r,
	input modelState_t st);
	if (mWritesRd(st.mem) && (st.mem[6:0] != hazardPkg::opLoad) && (st.mem[11:7] == r))
		return hazardPkg::fwdMem;
	if (mWritesRd(st.wb) && (st.wb[11:7] == r))
		return hazardPkg::fwdWb;
	return hazardPkg::fwdNone;
endfunction

function automatic modelOut_t modelEval(input modelState_t st,
	input hazardPkg::instWord_t dec, input logic brEq, input logic brLt);
	modelOut_t o;
	logic [6:0] exOp;
	logic taken;
	logic hit;
	exOp = st.ex[6:0];
	o.fwdA = hazardPkg::fwdNone;
	o.fwdB = hazardPkg::fwdNone;
	o.fwdStore = hazardPkg::fwdNone;
	if (mReadsRs1(st.ex))
		o.fwdA = mSrc(st.ex[19:15], st);
	if (mReadsRs2(st.ex))
	begin
		if (exOp == hazardPkg::opStore)
			o.fwdStore = mSrc(st.ex[24:20], st);
		else
			o.fwdB = mSrc(st.ex[24:20], st);
	end
	case (st.ex[14:12])
		hazardPkg::f3Beq: taken = brEq;
		hazardPkg::f3Bne: taken = !brEq;
		hazardPkg::f3Blt, hazardPkg::f3Bltu: taken = brLt;
		hazardPkg::f3Bge, hazardPkg::f3Bgeu: taken = !brLt;
		default: taken = 1'b0;
	endcase
	o.pcSelect = (exOp == hazardPkg::opJal) || (exOp == hazardPkg::opJalr)
		|| ((exOp == hazardPkg::opBranch) && taken);
	o.flush = o.pcSelect;
	hit = (mReadsRs1(dec) && (dec[19:15] == st.ex[11:7]))
		|| (mReadsRs2(dec) && (dec[24:20] == st.ex[11:7]));
	o.stall = (exOp == hazardPkg::opLoad) && mWritesRd(st.ex) && hit && !o.flush;
	return o;
endfunction

function automatic modelState_t modelStep(input modelState_t st,
	input hazardPkg::instWord_t dec, input modelOut_t o);
	modelState_t n;
	if (o.stall || o.flush)
		n.ex = hazardPkg::bubbleInst;
	else
		n.ex = dec;
	n.mem = st.ex;
	n.wb = st.mem;
	return n;
endfunction

`endif

//--- testbench/hazardCtrlTb.sv
module hazardCtrlTb;

	`include "hazardModel.svh"

	localparam int unsigned maxCycles = 2500; // Five tests of up to 400 cycles plus margin

	localparam logic [2:0] branchF3 [6] = '{hazardPkg::f3Beq, hazardPkg::f3Bne,
		hazardPkg::f3Blt, hazardPkg::f3Bge, hazardPkg::f3Bltu, hazardPkg::f3Bgeu};

	logic clk;
	logic rstN;
	hazardPkg::instWord_t decInst;
	logic brEq;
	logic brLt;
	hazardPkg::fwdSel_e forwardA;
	hazardPkg::fwdSel_e forwardB;
	hazardPkg::fwdSel_e forwardStore;
	logic stall;
	logic flush;
	logic pcSelect;

	modelState_t st;
	modelOut_t exp;
	int unsigned errors;
	int unsigned testStart;
	int unsigned testsPassed;
	int unsigned testsFailed;
	int unsigned cycles;
	logic [31:0] rng;

	hazardCtrl u_dut (
		.clk(clk),
		.rstN(rstN),
		.decInst(decInst),
		.brEq(brEq),
		.brLt(brLt),
		.forwardA(forwardA),
		.forwardB(forwardB),
		.forwardStore(forwardStore),
		.stall(stall),
		.flush(flush),
		.pcSelect(pcSelect)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Reference pipeline with the shift and bubble rule of the core
	always_comb
		exp = modelEval(st, decInst, brEq, brLt);

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
			st <= '0;
		else
			st <= modelStep(st, decInst, exp);
	end

	task automatic reportMismatch(input string sig, input int expV, input int actV);
		errors++;
		$display("CHECK FAILED t=%0t %s expected %0d actual %0d", $time, sig, expV, actV);
	endtask

	chkFwdA: assert property (@(negedge clk) disable iff (!rstN) forwardA == exp.fwdA)
		else reportMismatch("forwardA", exp.fwdA, forwardA);
	chkFwdB: assert property (@(negedge clk) disable iff (!rstN) forwardB == exp.fwdB)
		else reportMismatch("forwardB", exp.fwdB, forwardB);
	chkFwdStore: assert property (@(negedge clk) disable iff (!rstN)
		forwardStore == exp.fwdStore)
		else reportMismatch("forwardStore", exp.fwdStore, forwardStore);
	chkStall: assert property (@(negedge clk) disable iff (!rstN) stall == exp.stall)
		else reportMismatch("stall", exp.stall, stall);
	chkFlush: assert property (@(negedge clk) disable iff (!rstN) flush == exp.flush)
		else reportMismatch("flush", exp.flush, flush);
	chkPcSel: assert property (@(negedge clk) disable iff (!rstN) pcSelect == exp.pcSelect)
		else reportMismatch("pcSelect", exp.pcSelect, pcSelect);

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= maxCycles)
		begin
			$display("Run timed out after %0d cycles", cycles);
			$display("Regression failed");
			$finish;
		end
	end

	// Core holds decInst while stall is high
	task automatic issue(input hazardPkg::instWord_t inst, input logic eq, input logic lt);
		logic held;
		decInst <= inst;
		brEq <= eq;
		brLt <= lt;
		do
		begin
			@(negedge clk);
			held = stall;
			@(posedge clk);
		end
		while (held);
	endtask

	task automatic drain();
		repeat (4) issue(hazardPkg::bubbleInst, 1'b0, 1'b0);
	endtask

	task automatic endTest(input string name);
		if (errors == testStart)
		begin
			testsPassed++;
			$display("Test %s: ok", name);
		end
		else
		begin
			testsFailed++;
			$display("Test %s: %0d mismatches", name, errors - testStart);
		end
		testStart = errors;
	endtask

	initial
	begin
		rstN = 1'b0;
		decInst = hazardPkg::bubbleInst;
		brEq = 1'b0;
		brLt = 1'b0;
		errors = 0;
		testStart = 0;
		testsPassed = 0;
		testsFailed = 0;
		cycles = 0;
		repeat (4) @(posedge clk);
		rstN <= 1'b1;
		drain();
		endTest("reset idle");

		issue(mkAlu(5'd1, 5'd2, 5'd3), 1'b0, 1'b0);
		issue(mkAlu(5'd1, 5'd4, 5'd5), 1'b0, 1'b0);
		issue(mkAlu(5'd5, 5'd1, 5'd1), 1'b0, 1'b0); // MEM beats WB on x1
		issue(mkAlu(5'd0, 5'd1, 5'd2), 1'b0, 1'b0);
		issue(mkAlu(5'd6, 5'd0, 5'd0), 1'b0, 1'b0); // x0 never forwarded
		drain();
		issue(mkAlu(5'd2, 5'd1, 5'd1), 1'b0, 1'b0);
		issue(mkAlu(5'd3, 5'd1, 5'd1), 1'b0, 1'b0);
		issue(mkStore(5'd2, 5'd3), 1'b0, 1'b0);
		drain();
		endTest("alu and store forwarding");

		issue(mkLoad(5'd4, 5'd1), 1'b0, 1'b0);
		issue(mkAlu(5'd5, 5'd4, 5'd4), 1'b0, 1'b0);
		issue(mkLoad(5'd6, 5'd1), 1'b0, 1'b0);
		issue(mkStore(5'd1, 5'd6), 1'b0, 1'b0);
		drain();
		endTest("load use");

		for (int i = 0; i < 6; i++)
		begin
			for (int c = 0; c < 4; c++)
			begin
				issue(mkBranch(branchF3[i], 5'd1, 5'd2), 1'b0, 1'b0);
				issue(hazardPkg::bubbleInst, c[0], c[1]); // Flags seen with branch in EX
			end
		end
		issue(mkJal(5'd1), 1'b0, 1'b0);
		issue(hazardPkg::bubbleInst, 1'b0, 1'b0);
		issue(mkJalr(5'd1, 5'd2), 1'b0, 1'b0);
		issue(hazardPkg::bubbleInst, 1'b1, 1'b1);
		issue(mkLoad(5'd7, 5'd1), 1'b0, 1'b0);
		issue(mkJalr(5'd0, 5'd7), 1'b0, 1'b0);
		issue(mkAlu(5'd8, 5'd7, 5'd7), 1'b0, 1'b0); // Killed by the JALR flush
		issue(mkAlu(5'd9, 5'd8, 5'd8), 1'b0, 1'b0); // Sees no x8 producer in MEM
		drain();
		endTest("branch and jump redirect");

		rng = hazardPkg::rngSeed;
		repeat (300)
		begin
			rng = xorshift32(rng);
			issue(randInst(rng), rng[13], rng[14]);
		end
		drain();
		endTest("random stream");

		$display("Tests passed %0d, failed %0d, mismatches %0d", testsPassed, testsFailed,
			errors);
		if (testsFailed == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

//--- verilog/hazardCtrl.sv
module hazardCtrl (
	input logic clk,
	input logic rstN,
	input hazardPkg::instWord_t decInst,
	input logic brEq,
	input logic brLt,
	output hazardPkg::fwdSel_e forwardA,
	output hazardPkg::fwdSel_e forwardB,
	output hazardPkg::fwdSel_e forwardStore,
	output logic stall,
	output logic flush,
	output logic pcSelect
);

	hazardPkg::instWord_t exInst;
	hazardPkg::instWord_t memInst;
	hazardPkg::instWord_t wbInst;

	stageIf decStage();
	stageIf exStage();
	stageIf memStage();
	stageIf wbStage();

	pipeTracker uTracker (
		.clk(clk),
		.rstN(rstN),
		.decInst(decInst),
		.stall(stall),
		.flush(flush),
		.exInst(exInst),
		.memInst(memInst),
		.wbInst(wbInst)
	);

	stageDecode uDecDecode (
		.inst(decInst), // Straight from the core
		.info(decStage)
	);

	stageDecode uExDecode (
		.inst(exInst),
		.info(exStage)
	);

	stageDecode uMemDecode (
		.inst(memInst),
		.info(memStage)
	);

	stageDecode uWbDecode (
		.inst(wbInst),
		.info(wbStage)
	);

	forwardSelect uForward (
		.exStage(exStage),
		.memStage(memStage),
		.wbStage(wbStage),
		.forwardA(forwardA),
		.forwardB(forwardB),
		.forwardStore(forwardStore)
	);

	redirectCtrl uRedirect (
		.decStage(decStage),
		.exStage(exStage),
		.brEq(brEq),
		.brLt(brLt),
		.stall(stall),
		.flush(flush),
		.pcSelect(pcSelect)
	);

endmodule

//--- verilog/redirectCtrl.sv
module redirectCtrl (
	stageIf.consumer decStage,
	stageIf.consumer exStage,
	input logic brEq,
	input logic brLt,
	output logic stall,
	output logic flush,
	output logic pcSelect
);

	logic condTrue;
	logic isJump;
	logic redirect;
	logic loadUse;

	always_comb
	begin
		case (exStage.funct3)
			hazardPkg::f3Beq:
				condTrue = brEq;
			hazardPkg::f3Bne:
				condTrue = !brEq;
			hazardPkg::f3Blt,
			hazardPkg::f3Bltu:
				condTrue = brLt; // Core picks signed or unsigned compare
			hazardPkg::f3Bge,
			hazardPkg::f3Bgeu:
				condTrue = !brLt;
			default:
				condTrue = 1'b0;
		endcase
	end

	assign isJump = (exStage.opClass == hazardPkg::clsJal)
		|| (exStage.opClass == hazardPkg::clsJalr);

	assign redirect = isJump || ((exStage.opClass == hazardPkg::clsBranch) && condTrue);

	// Load in EX feeding the instruction in decode
	assign loadUse = (exStage.opClass == hazardPkg::clsLoad) && exStage.writesRd
		&& ((decStage.readsRs1 && (decStage.rs1 == exStage.rd))
		|| (decStage.readsRs2 && (decStage.rs2 == exStage.rd)));

	assign pcSelect = redirect;
	assign flush = redirect;
	assign stall = loadUse && !redirect; // Decode word is discarded anyway

endmodule

//--- verilog/forwardSelect.sv
module forwardSelect (
	stageIf.consumer exStage,
	stageIf.consumer memStage,
	stageIf.consumer wbStage,
	output hazardPkg::fwdSel_e forwardA,
	output hazardPkg::fwdSel_e forwardB,
	output hazardPkg::fwdSel_e forwardStore
);

	logic memOk;
	hazardPkg::fwdSel_e srcRs1;
	hazardPkg::fwdSel_e srcRs2;

	// Youngest producer wins
	function automatic hazardPkg::fwdSel_e pickSrc(
		input hazardPkg::regAddr_t src,
		input logic memWr,
		input hazardPkg::regAddr_t memRd,
		input logic wbWr,
		input hazardPkg::regAddr_t wbRd
	);
		if (memWr && (memRd == src))
			return hazardPkg::fwdMem;
		else if (wbWr && (wbRd == src))
			return hazardPkg::fwdWb;
		return hazardPkg::fwdNone;
	endfunction

	assign memOk = memStage.writesRd
		&& (memStage.opClass != hazardPkg::clsLoad); // Load data not ready

	always_comb
	begin
		srcRs1 = hazardPkg::fwdNone;
		srcRs2 = hazardPkg::fwdNone;
		if (exStage.readsRs1)
			srcRs1 = pickSrc(exStage.rs1, memOk, memStage.rd, wbStage.writesRd, wbStage.rd);
		if (exStage.readsRs2)
			srcRs2 = pickSrc(exStage.rs2, memOk, memStage.rd, wbStage.writesRd, wbStage.rd);
	end

	always_comb
	begin
		forwardA = srcRs1;
		forwardB = hazardPkg::fwdNone;
		forwardStore = hazardPkg::fwdNone;
		if (exStage.opClass == hazardPkg::clsStore)
			forwardStore = srcRs2; // rs2 is store data
		else
			forwardB = srcRs2;
	end

endmodule

//--- verilog/pipeTracker.sv
module pipeTracker (
	input logic clk,
	input logic rstN,
	input hazardPkg::instWord_t decInst,
	input logic stall,
	input logic flush,
	output hazardPkg::instWord_t exInst,
	output hazardPkg::instWord_t memInst,
	output hazardPkg::instWord_t wbInst
);

	logic killDec; // Decode word must not enter EX

	assign killDec = stall || flush;

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			exInst <= hazardPkg::bubbleInst;
			memInst <= hazardPkg::bubbleInst;
			wbInst <= hazardPkg::bubbleInst;
		end
		else
		begin
			if (killDec)
				exInst <= hazardPkg::bubbleInst;
			else
				exInst <= decInst;
			memInst <= exInst;
			wbInst <= memInst;
		end
	end

endmodule

//--- verilog/stageDecode.sv
module stageDecode (
	input hazardPkg::instWord_t inst,
	stageIf.producer info
);

	logic [6:0] opcode;
	logic isUpper; // LUI and AUIPC read no source register
	hazardPkg::opClass_e cls;

	assign opcode = inst[6:0];
	assign isUpper = (opcode == hazardPkg::opLui) || (opcode == hazardPkg::opAuipc);

	always_comb
	begin
		case (opcode)
			hazardPkg::opR,
			hazardPkg::opI,
			hazardPkg::opLui,
			hazardPkg::opAuipc:
				cls = hazardPkg::clsAlu;
			hazardPkg::opLoad:
				cls = hazardPkg::clsLoad;
			hazardPkg::opStore:
				cls = hazardPkg::clsStore;
			hazardPkg::opBranch:
				cls = hazardPkg::clsBranch;
			hazardPkg::opJal:
				cls = hazardPkg::clsJal;
			hazardPkg::opJalr:
				cls = hazardPkg::clsJalr;
			default:
				cls = hazardPkg::clsNone; // Bubble and unknown opcodes
		endcase
	end

	assign info.opClass = cls;
	assign info.rs1 = inst[19:15];
	assign info.rs2 = inst[24:20];
	assign info.rd = inst[11:7];
	assign info.funct3 = inst[14:12];

	// x0 reads never create a dependency
	assign info.readsRs1 = (cls inside {hazardPkg::clsAlu, hazardPkg::clsLoad,
		hazardPkg::clsStore, hazardPkg::clsBranch, hazardPkg::clsJalr})
		&& !isUpper && (inst[19:15] != '0);

	assign info.readsRs2 = ((opcode == hazardPkg::opR) || (cls == hazardPkg::clsStore)
		|| (cls == hazardPkg::clsBranch)) && (inst[24:20] != '0);

	assign info.writesRd = (cls inside {hazardPkg::clsAlu, hazardPkg::clsLoad,
		hazardPkg::clsJal, hazardPkg::clsJalr}) && (inst[11:7] != '0);

endmodule

//--- verilog/stageIf.sv
interface stageIf;

	hazardPkg::opClass_e opClass;
	hazardPkg::regAddr_t rs1;
	hazardPkg::regAddr_t rs2;
	hazardPkg::regAddr_t rd;
	logic [2:0] funct3;
	logic readsRs1;
	logic readsRs2;
	logic writesRd; // Never set for rd of x0

	modport producer (
		output opClass, rs1, rs2, rd, funct3,
		output readsRs1, readsRs2, writesRd
	);

	modport consumer (
		input opClass, rs1, rs2, rd, funct3,
		input readsRs1, readsRs2, writesRd
	);

endinterface

//--- verilog/hazardPkg.sv
package hazardPkg;

	localparam int instWidth = 32;
	localparam int regAddrWidth = 5;

	typedef logic [instWidth-1:0] instWord_t;
	typedef logic [regAddrWidth-1:0] regAddr_t;

	localparam instWord_t bubbleInst = '0; // Empty stage

	// RV32I major opcodes
	localparam logic [6:0] opR = 7'b0110011;
	localparam logic [6:0] opI = 7'b0010011;
	localparam logic [6:0] opLoad = 7'b0000011;
	localparam logic [6:0] opStore = 7'b0100011;
	localparam logic [6:0] opBranch = 7'b1100011;
	localparam logic [6:0] opJal = 7'b1101111;
	localparam logic [6:0] opJalr = 7'b1100111;
	localparam logic [6:0] opLui = 7'b0110111;
	localparam logic [6:0] opAuipc = 7'b0010111;

	localparam logic [2:0] f3Beq = 3'b000;
	localparam logic [2:0] f3Bne = 3'b001;
	localparam logic [2:0] f3Blt = 3'b100;
	localparam logic [2:0] f3Bge = 3'b101;
	localparam logic [2:0] f3Bltu = 3'b110;
	localparam logic [2:0] f3Bgeu = 3'b111;

	typedef enum logic [2:0]
	{
		clsNone,
		clsAlu, // R, I, LUI, AUIPC
		clsLoad,
		clsStore,
		clsBranch,
		clsJal,
		clsJalr
	} opClass_e;

	typedef enum logic [1:0]
	{
		fwdNone = 2'd0, // Register file
		fwdWb = 2'd1,
		fwdMem = 2'd2
	} fwdSel_e;

	localparam logic [31:0] rngSeed = 32'had7b_c34f; // Stimulus generator start value

endpackage
